// ==== project.f ====
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard.sv
verilog/rv_core.sv
test/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f project.f --top-module tb_rv_core -o tb_rv_core &&
  ./obj_dir/tb_rv_core | tee /dev/stderr | grep -q "TEST PASSED" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// ==== test/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int IMEM_DEPTH = 256;
  localparam int DMEM_DEPTH = 256;
  localparam int PROG_LEN   = 200;
  localparam int PROLOGUE   = 15;  // 7 register seeds, then 8 memory seeds

  typedef enum {k_reg, k_addi, k_lw, k_sw, k_beq, k_bne, k_jal} kind_e;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            imem_we;
  logic [XLEN-1:0] imem_addr;
  logic [XLEN-1:0] imem_wdata;
  logic            retire_valid;
  retire_t         retire;

  kind_e           kind_q [PROG_LEN];
  alu_op_e         op_q   [PROG_LEN];
  logic [4:0]      rd_q   [PROG_LEN];
  logic [4:0]      rs1_q  [PROG_LEN];
  logic [4:0]      rs2_q  [PROG_LEN];
  logic [XLEN-1:0] imm_q  [PROG_LEN];
  logic [XLEN-1:0] prog   [PROG_LEN];
  retire_t         expected [$];

  logic [31:0] lfsr_state = 32'hc575_a5a8;
  int          n_rec = 0;
  int          timeout_cycles = 0;
  int          cycles = 0;
  int          matched = 0;
  logic        failed = 1'b0;

  rv_core #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) rv_core_inst (
    .clk, .arst_n, .imem_we, .imem_addr, .imem_wdata, .retire_valid, .retire
  );

  always #2 clk = ~clk;  // 4 ns period

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};  // one step per bit
    end
    return r;
  endfunction

  function automatic logic [31:0] encode(input kind_e k, input alu_op_e op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [31:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'b000;
    f7 = 7'b0000000;
    case (op)
      alu_sub: f7 = 7'b0100000;
      alu_and: f3 = 3'b111;
      alu_or:  f3 = 3'b110;
      alu_xor: f3 = 3'b100;
      alu_slt: f3 = 3'b010;
      default: ;
    endcase
    case (k)
      k_reg:   encode = {f7, rs2, rs1, f3, rd, op_reg};
      k_addi:  encode = {imm[11:0], rs1, 3'b000, rd, op_imm};
      k_lw:    encode = {imm[11:0], 5'd0, 3'b010, rd, op_load};
      k_sw:    encode = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], op_store};
      k_beq:   encode = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], op_branch};
      k_bne:   encode = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], op_branch};
      default: encode = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endcase
  endfunction

  task automatic set_instr(input int i, input kind_e k, input alu_op_e op, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
    kind_q[i] = k;
    op_q[i]   = op;
    rd_q[i]   = rd;
    rs1_q[i]  = rs1;
    rs2_q[i]  = rs2;
    imm_q[i]  = imm;
    prog[i]   = encode(k, op, rd, rs1, rs2, imm);
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    logic [31:0] imm;
    kind_e       k;
    alu_op_e     op;
    int          off;
    for (int i = 0; i < 7; i++) begin
      r = rand_bits(12);
      set_instr(i, k_addi, alu_add, 5'(i + 1), 5'd0, 5'd0, {{20{r[11]}}, r[11:0]});
    end
    for (int i = 0; i < 8; i++) begin
      set_instr(7 + i, k_sw, alu_add, 5'd0, 5'd0, 5'(i), 32'(i * 4));  // every data word defined
    end
    for (int i = PROLOGUE; i < PROG_LEN - 1; i++) begin
      r   = rand_bits(3);
      rd  = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      case (r[2:0])
        3'd0, 3'd1: k = k_reg;
        3'd2:       k = k_addi;
        3'd3:       k = k_lw;
        3'd4:       k = k_sw;
        3'd5:       k = k_beq;
        3'd6:       k = k_bne;
        default:    k = k_jal;
      endcase
      // targets must stay inside the program
      if (k inside {k_beq, k_bne, k_jal} && i + 6 > PROG_LEN - 1) k = k_addi;
      op  = alu_add;
      imm = '0;
      case (k)
        k_reg: op = alu_op_e'(3'(int'(rand_bits(3)) % 6));
        k_addi: begin
          r   = rand_bits(12);
          imm = {{20{r[11]}}, r[11:0]};
        end
        k_lw, k_sw: begin
          r   = rand_bits(3);
          imm = {27'd0, r[2:0], 2'b00};
          rs1 = 5'd0;  // base x0
        end
        k_beq, k_bne: begin
          r   = rand_bits(4);
          off = 2 + int'(r[2:0]) % 5;
          if (r[3]) rs2 = rs1;  // same register, beq taken
          imm = 32'(off * 4);
        end
        default: begin
          r   = rand_bits(3);
          off = 2 + int'(r[2:0]) % 5;
          imm = 32'(off * 4);
        end
      endcase
      set_instr(i, k, op, rd, rs1, rs2, imm);
    end
    set_instr(PROG_LEN - 1, k_jal, alu_add, 5'd0, 5'd0, 5'd0, 32'd0);  // jal to itself
  endtask

  function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      alu_sub: alu_model = a - b;
      alu_and: alu_model = a & b;
      alu_or:  alu_model = a | b;
      alu_xor: alu_model = a ^ b;
      alu_slt: alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: alu_model = a + b;
    endcase
  endfunction

  // architectural run, one record per executed instruction
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] dmem_model [8];
    logic [31:0] a, b, wd;
    logic        we;
    retire_t     rec;
    int          idx, next;
    for (int k = 0; k < 32; k++) regs[k] = '0;
    for (int k = 0; k < 8; k++) dmem_model[k] = '0;
    idx = 0;
    while (idx < PROG_LEN - 1) begin
      a    = regs[rs1_q[idx]];
      b    = regs[rs2_q[idx]];
      we   = 1'b0;
      wd   = '0;
      next = idx + 1;
      case (kind_q[idx])
        k_reg:  begin wd = alu_model(op_q[idx], a, b); we = 1'b1; end
        k_addi: begin wd = a + imm_q[idx]; we = 1'b1; end
        k_lw:   begin wd = dmem_model[imm_q[idx][4:2]]; we = 1'b1; end
        k_sw:   dmem_model[imm_q[idx][4:2]] = b;
        k_beq:  if (a == b) next = idx + int'(imm_q[idx]) / 4;
        k_bne:  if (a != b) next = idx + int'(imm_q[idx]) / 4;
        default: begin
          wd   = 32'(idx * 4 + 4);
          we   = 1'b1;
          next = idx + int'(imm_q[idx]) / 4;
        end
      endcase
      rec.pc        = 32'(idx * 4);
      rec.rd        = rd_q[idx];
      rec.reg_write = we && rd_q[idx] != 5'd0;
      rec.wdata     = wd;
      if (rec.reg_write) regs[rd_q[idx]] = wd;
      expected.push_back(rec);
      idx = next;
    end
    rec.pc        = 32'((PROG_LEN - 1) * 4);
    rec.rd        = 5'd0;
    rec.reg_write = 1'b0;
    rec.wdata     = rec.pc + 32'd4;
    repeat (3) expected.push_back(rec);  // self loop seen three times
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    failed = 1'b1;
  endtask

  // rd and wdata only carry meaning when the register is written
  task automatic check_retire(input retire_t exp, input retire_t act);
    if (act.pc !== exp.pc)
      report_mismatch("retire.pc", exp.pc, act.pc);
    else if (act.reg_write !== exp.reg_write)
      report_mismatch("retire.reg_write", {31'd0, exp.reg_write}, {31'd0, act.reg_write});
    else if (exp.reg_write && act.rd !== exp.rd)
      report_mismatch("retire.rd", {27'd0, exp.rd}, {27'd0, act.rd});
    else if (exp.reg_write && act.wdata !== exp.wdata)
      report_mismatch("retire.wdata", exp.wdata, act.wdata);
  endtask

  initial begin
    arst_n     = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    build_program();
    run_model();
    n_rec          = expected.size();
    timeout_cycles = 4 * n_rec + 50;
    for (int i = 0; i < PROG_LEN; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= 32'(i * 4);
      imem_wdata <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (5) @(posedge clk);  // reset cycles after the load
    arst_n <= 1'b1;
  end

  // outputs settle after the rising edge, sample on the falling one
  always @(negedge clk) begin
    if (arst_n) begin
      cycles = cycles + 1;
      if (retire_valid) begin
        check_retire(expected[matched], retire);
        matched = matched + 1;
      end
      if (!failed && matched < n_rec && cycles >= timeout_cycles) begin
        $display("timeout: the core stopped retiring, %0d of %0d records after %0d cycles",
                 matched, n_rec, cycles);
        failed = 1'b1;
      end
      if (failed) begin
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
      end else if (matched == n_rec) begin
        $display("TEST PASSED");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    imem_we,
  input  wire logic [rv_pkg::XLEN-1:0] imem_addr,
  input  wire logic [rv_pkg::XLEN-1:0] imem_wdata,
  output logic                         retire_valid,
  output rv_pkg::retire_t              retire
);
  import rv_pkg::*;

  if_id_t                if_id;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;
  logic [REG_ADDR_W-1:0] d_rs1, d_rs2;
  logic                  jal_taken;
  logic [XLEN-1:0]       jal_target;
  pc_src_e               e_pc_src;
  logic [XLEN-1:0]       br_target;
  fwd_sel_e              fwd_a, fwd_b;
  logic                  f_stall, d_stall, d_flush, e_flush;

  fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_stage_inst (
    .clk, .arst_n, .imem_we, .imem_addr, .imem_wdata,
    .stall(f_stall), .flush(d_flush),
    .jal_taken, .jal_target, .pc_src(e_pc_src), .br_target,
    .if_id
  );

  decode_stage decode_stage_inst (
    .clk, .arst_n, .if_id, .mem_wb,
    .stall(d_stall), .flush(e_flush),
    .rs1(d_rs1), .rs2(d_rs2), .jal_taken, .jal_target,
    .id_ex
  );

  execute_stage execute_stage_inst (
    .clk, .arst_n, .id_ex, .fwd_a, .fwd_b, .mem_wb,
    .pc_src(e_pc_src), .br_target, .ex_mem
  );

  memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) memory_stage_inst (
    .clk, .arst_n, .ex_mem, .mem_wb, .retire_valid, .retire
  );

  hazard hazard_inst (
    .clk,
    .d_rs1, .d_rs2, .d_jal(jal_taken),
    .e_rs1(id_ex.rs1), .e_rs2(id_ex.rs2), .e_rd(id_ex.rd),
    .e_is_load(id_ex.is_load), .e_pc_src,
    .m_rd(ex_mem.rd), .m_reg_write(ex_mem.reg_write),
    .w_rd(mem_wb.rd), .w_reg_write(mem_wb.reg_write),
    .fwd_a, .fwd_b, .f_stall, .d_stall, .d_flush, .e_flush
  );

endmodule

`default_nettype wire

// ==== verilog/hazard.sv ====
`timescale 1ns/100ps
`default_nettype none

module hazard (
  input  wire logic                             clk,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    d_rs1,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    d_rs2,
  input  wire logic                             d_jal,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    e_rs1,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    e_rs2,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    e_rd,
  input  wire logic                             e_is_load,
  input  wire rv_pkg::pc_src_e                  e_pc_src,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    m_rd,
  input  wire logic                             m_reg_write,
  input  wire logic [rv_pkg::REG_ADDR_W-1:0]    w_rd,
  input  wire logic                             w_reg_write,
  output rv_pkg::fwd_sel_e                      fwd_a,
  output rv_pkg::fwd_sel_e                      fwd_b,
  output logic                                  f_stall,
  output logic                                  d_stall,
  output logic                                  d_flush,
  output logic                                  e_flush
);
  import rv_pkg::*;

  logic lw_stall;
  logic redirect;

  // memory stage first, then writeback, x0 is never forwarded
  function automatic fwd_sel_e fwd_select(
    input logic [REG_ADDR_W-1:0] rs,
    input logic [REG_ADDR_W-1:0] mem_rd,
    input logic                  mem_we,
    input logic [REG_ADDR_W-1:0] wb_rd,
    input logic                  wb_we
  );
    if (rs == '0)                     fwd_select = fwd_rf;
    else if (rs == mem_rd && mem_we)  fwd_select = fwd_mem;
    else if (rs == wb_rd && wb_we)    fwd_select = fwd_wb;
    else                              fwd_select = fwd_rf;
  endfunction

  assign fwd_a = fwd_select(e_rs1, m_rd, m_reg_write, w_rd, w_reg_write);
  assign fwd_b = fwd_select(e_rs2, m_rd, m_reg_write, w_rd, w_reg_write);

  assign lw_stall = e_is_load && e_rd != '0 && (d_rs1 == e_rd || d_rs2 == e_rd);
  assign redirect = e_pc_src != pc_seq;  // taken branch

  assign f_stall = lw_stall;
  assign d_stall = lw_stall;
  assign d_flush = redirect | d_jal;
  assign e_flush = redirect | lw_stall;

  // a load in execute can never be a taken branch as well
  a_stall_vs_redirect: assert property (@(posedge clk) !(lw_stall && redirect));

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage #(
  parameter int DMEM_DEPTH = 256
) (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire rv_pkg::ex_mem_t ex_mem,
  output rv_pkg::mem_wb_t      mem_wb,
  output logic                 retire_valid,
  output rv_pkg::retire_t      retire
);
  import rv_pkg::*;

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  logic [XLEN-1:0]    dmem [DMEM_DEPTH];
  logic [DMEM_AW-1:0] word_idx;
  logic [XLEN-1:0]    load_data;

  assign word_idx = ex_mem.alu_result[DMEM_AW+1:2];  // word addressed

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.is_store) dmem[word_idx] <= ex_mem.store_data;
  end

  assign load_data = dmem[word_idx];  // async read

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.pc        <= ex_mem.pc;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.result    <= ex_mem.is_load ? load_data : ex_mem.alu_result;
      mem_wb.reg_write <= ex_mem.reg_write;
    end
  end

  // one record per instruction leaving writeback
  assign retire_valid     = mem_wb.valid;
  assign retire.pc        = mem_wb.pc;
  assign retire.rd        = mem_wb.rd;
  assign retire.reg_write = mem_wb.reg_write;
  assign retire.wdata     = mem_wb.result;

  a_word_access: assert property (@(posedge clk) disable iff (!arst_n)
    ex_mem.valid && (ex_mem.is_load || ex_mem.is_store) |-> ex_mem.alu_result[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire rv_pkg::id_ex_t          id_ex,
  input  wire rv_pkg::fwd_sel_e        fwd_a,
  input  wire rv_pkg::fwd_sel_e        fwd_b,
  input  wire rv_pkg::mem_wb_t         mem_wb,
  output rv_pkg::pc_src_e              pc_src,
  output logic [rv_pkg::XLEN-1:0]      br_target,
  output rv_pkg::ex_mem_t              ex_mem
);
  import rv_pkg::*;

  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_out;
  logic            lt;
  logic            eq;
  logic            taken;

  always_comb begin
    case (fwd_a)
      fwd_mem: src_a = ex_mem.alu_result;
      fwd_wb:  src_a = mem_wb.result;
      default: src_a = id_ex.rd1;
    endcase
  end

  always_comb begin
    case (fwd_b)
      fwd_mem: src_b = ex_mem.alu_result;
      fwd_wb:  src_b = mem_wb.result;
      default: src_b = id_ex.rd2;
    endcase
  end

  // jal hands its return address to the ALU, which passes it through
  assign alu_b = id_ex.link    ? id_ex.pc + XLEN'(4) :
                 id_ex.use_imm ? id_ex.imm           : src_b;
  assign lt    = $signed(src_a) < $signed(alu_b);

  always_comb begin
    case (id_ex.alu_op)
      alu_add:    alu_out = src_a + alu_b;
      alu_sub:    alu_out = src_a - alu_b;
      alu_and:    alu_out = src_a & alu_b;
      alu_or:     alu_out = src_a | alu_b;
      alu_xor:    alu_out = src_a ^ alu_b;
      alu_slt:    alu_out = {{(XLEN-1){1'b0}}, lt};
      alu_pass_b: alu_out = alu_b;
      default:    alu_out = '0;
    endcase
  end

  // branch compare on forwarded operands
  assign eq        = src_a == src_b;
  assign taken     = id_ex.valid && ((id_ex.is_beq && eq) || (id_ex.is_bne && !eq));
  assign pc_src    = taken ? pc_branch : pc_seq;
  assign br_target = id_ex.pc + id_ex.imm;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.pc         <= id_ex.pc;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.alu_result <= alu_out;
      ex_mem.store_data <= src_b;
      ex_mem.is_load    <= id_ex.is_load;
      ex_mem.is_store   <= id_ex.is_store;
      ex_mem.reg_write  <= id_ex.reg_write;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  input  wire rv_pkg::if_id_t                if_id,
  input  wire rv_pkg::mem_wb_t               mem_wb,
  input  wire logic                          stall,
  input  wire logic                          flush,
  output logic [rv_pkg::REG_ADDR_W-1:0]      rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0]      rs2,
  output logic                               jal_taken,
  output logic [rv_pkg::XLEN-1:0]            jal_target,
  output rv_pkg::id_ex_t                     id_ex
);
  import rv_pkg::*;

  logic [XLEN-1:0]       rf [32];
  logic [XLEN-1:0]       instr;
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_j;
  logic                  uses_rs1, uses_rs2;
  logic                  wb_we;
  logic [XLEN-1:0]       rd1, rd2;
  id_ex_t                dec;

  function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic sub_bit);
    case (f3)
      3'b000:  alu_fn = sub_bit ? alu_sub : alu_add;
      3'b010:  alu_fn = alu_slt;
      3'b100:  alu_fn = alu_xor;
      3'b110:  alu_fn = alu_or;
      3'b111:  alu_fn = alu_and;
      default: alu_fn = alu_add;
    endcase
  endfunction

  assign instr  = if_id.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // unused source fields read as x0 so they never match in the hazard unit
  assign uses_rs1 = if_id.valid && opcode inside {op_reg, op_imm, op_load, op_store, op_branch};
  assign uses_rs2 = if_id.valid && opcode inside {op_reg, op_store, op_branch};
  assign rs1      = uses_rs1 ? instr[19:15] : '0;
  assign rs2      = uses_rs2 ? instr[24:20] : '0;

  assign jal_taken  = if_id.valid && opcode == op_jal;
  assign jal_target = if_id.pc + imm_j;

  assign wb_we = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != '0;

  always_ff @(posedge clk) begin
    if (wb_we) rf[mem_wb.rd] <= mem_wb.result;
  end

  // write-through from writeback
  assign rd1 = (rs1 == '0) ? '0 : (wb_we && mem_wb.rd == rs1) ? mem_wb.result : rf[rs1];
  assign rd2 = (rs2 == '0) ? '0 : (wb_we && mem_wb.rd == rs2) ? mem_wb.result : rf[rs2];

  always_comb begin
    dec        = '0;
    dec.valid  = if_id.valid;
    dec.pc     = if_id.pc;
    dec.rs1    = rs1;
    dec.rs2    = rs2;
    dec.rd     = instr[11:7];
    dec.rd1    = rd1;
    dec.rd2    = rd2;
    dec.alu_op = alu_add;
    case (opcode)
      op_reg:    begin dec.reg_write = 1'b1; dec.alu_op = alu_fn(funct3, instr[30]); end
      op_imm:    begin
        dec.reg_write = 1'b1;
        dec.use_imm   = 1'b1;
        dec.imm       = imm_i;
        dec.alu_op    = alu_fn(funct3, 1'b0);
      end
      op_load:   begin dec.reg_write = 1'b1; dec.is_load = 1'b1; dec.use_imm = 1'b1; dec.imm = imm_i; end
      op_store:  begin dec.is_store = 1'b1; dec.use_imm = 1'b1; dec.imm = imm_s; end
      op_branch: begin
        dec.is_beq = funct3 == 3'b000;
        dec.is_bne = funct3 == 3'b001;
        dec.imm    = imm_b;
        dec.alu_op = alu_sub;
      end
      op_jal:    begin dec.reg_write = 1'b1; dec.link = 1'b1; dec.imm = imm_j; dec.alu_op = alu_pass_b; end
      default:   ;  // unsupported, retires as a no-op
    endcase
    dec.reg_write = dec.reg_write && dec.rd != '0;  // x0 never written
    if (!if_id.valid) dec = '0;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (stall || flush) begin
      id_ex <= '0;  // bubble
    end else begin
      id_ex <= dec;
    end
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
    mem_wb.valid && mem_wb.reg_write |-> mem_wb.rd != '0);

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
  parameter int IMEM_DEPTH = 256
) (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    imem_we,
  input  wire logic [rv_pkg::XLEN-1:0] imem_addr,  // byte address
  input  wire logic [rv_pkg::XLEN-1:0] imem_wdata,
  input  wire logic                    stall,
  input  wire logic                    flush,
  input  wire logic                    jal_taken,
  input  wire logic [rv_pkg::XLEN-1:0] jal_target,
  input  wire rv_pkg::pc_src_e         pc_src,
  input  wire logic [rv_pkg::XLEN-1:0] br_target,
  output rv_pkg::if_id_t               if_id
);
  import rv_pkg::*;

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  logic [XLEN-1:0] imem [IMEM_DEPTH];
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_next;
  pc_src_e         next_src;

  // program load, only while the core sits in reset
  always_ff @(posedge clk) begin
    if (imem_we && !arst_n) imem[imem_addr[IMEM_AW+1:2]] <= imem_wdata;
  end

  // branch from execute wins over jal from decode
  always_comb begin
    if (pc_src == pc_branch) next_src = pc_branch;
    else if (jal_taken)      next_src = pc_jal;
    else                     next_src = pc_seq;
  end

  always_comb begin
    case (next_src)
      pc_branch: pc_next = br_target;
      pc_jal:    pc_next = jal_target;
      default:   pc_next = pc + XLEN'(4);
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (next_src != pc_seq || !stall) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      if_id <= '0;
    end else if (flush) begin
      if_id <= '0;  // squash wrong-path fetch
    end else if (!stall) begin
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= imem[pc[IMEM_AW+1:2]];
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  // operand source in execute, same codes as the forwarding function
  typedef enum logic [1:0] {
    fwd_rf  = 2'b00,
    fwd_mem = 2'b01,
    fwd_wb  = 2'b10
  } fwd_sel_e;

  typedef enum logic [1:0] {
    pc_seq    = 2'b00,
    pc_jal    = 2'b01,
    pc_branch = 2'b10
  } pc_src_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rd1;
    logic [XLEN-1:0]       rd2;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  is_load;
    logic                  is_store;
    logic                  is_beq;
    logic                  is_bne;
    logic                  reg_write;
    logic                  link;     // jal, result is pc+4
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       store_data;
    logic                  is_load;
    logic                  is_store;
    logic                  reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
    logic                  reg_write;
  } mem_wb_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write;
    logic [XLEN-1:0]       wdata;
  } retire_t;

endpackage

`default_nettype wire
